// File: Bender.yml
package:
  name: fpu_axil

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fpu_pkg.sv
      - source/fp_align_stage.sv
      - source/fp_add_stage.sv
      - source/fp_mul_stage.sv
      - source/fpu_axil_ctrl.sv
      - source/fpu_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/fpu_chk.sv
      - sim/fpu_tb.sv

// File: build.f
+incdir+source
source/fpu_pkg.sv
source/fp_align_stage.sv
source/fp_add_stage.sv
source/fp_mul_stage.sv
source/fpu_axil_ctrl.sv
source/fpu_top.sv
sim/fpu_chk.sv
sim/fpu_tb.sv

// File: sim/fpu_chk.sv
// FPU protocol assertions
`timescale 1ns/1ps

module fpu_chk
    import fpu_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       bvalid,
    input logic       bready,
    input logic [1:0] bresp,
    input logic       rvalid,
    input logic       rready,
    input scalar_t    rdata,
    input logic       issue_valid,
    input logic       done_valid,
    input logic       busy
);
    // Write response holds until the master takes it
    b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else
        $error("bvalid dropped or bresp changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else
        $error("rvalid dropped or rdata changed before rready");

    issue_pulse: assert property (@(posedge clk) disable iff (reset)
        issue_valid |=> !issue_valid)
    else
        $error("issue_valid high for more than one cycle");

    // Two pipeline stages between issue and done
    done_after_issue: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> ##2 done_valid)
    else
        $error("done_valid missing two cycles after issue_valid");

    done_needs_issue: assert property (@(posedge clk) disable iff (reset)
        done_valid |-> $past(issue_valid, 2))
    else
        $error("done_valid without issue_valid two cycles earlier");

    reset_idle: assert property (@(posedge clk) $fell(reset) |-> !busy)
    else
        $error("busy set when reset is released");

endmodule

bind fpu_axil_ctrl fpu_chk u_chk (
    .clk(clk),
    .reset(reset),
    .bvalid(bvalid),
    .bready(bready),
    .bresp(bresp),
    .rvalid(rvalid),
    .rready(rready),
    .rdata(rdata),
    .issue_valid(issue_valid),
    .done_valid(done_valid),
    .busy(busy)
);

// File: sim/fpu_tb.sv
// FPU coprocessor testbench
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_tb
    import fpu_pkg::*;
();
    localparam int NUM_VECTORS = 18;
    // Protocol section counts as four more entries
    localparam int TIMEOUT_CYCLES = (NUM_VECTORS + 4) * 200 + 10;
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        fp_op_t  op;
        scalar_t a;
        scalar_t b;
        scalar_t result;
        logic    nan;
        logic    inf;
    } vector_t;

    logic clk;
    logic reset;
    logic [`FPU_ADDR_WIDTH-1:0] awaddr;
    logic awvalid;
    logic awready;
    scalar_t wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [`FPU_ADDR_WIDTH-1:0] araddr;
    logic arvalid;
    logic arready;
    scalar_t rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    vector_t vectors [NUM_VECTORS];

    fpu_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input scalar_t got, input scalar_t expected);
        if (got !== expected)
            fail_run($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                               $time, name, got, expected));
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [`FPU_ADDR_WIDTH-1:0] addr, input scalar_t data,
                             input int max_delay, output logic [1:0] resp);
        int delay;
        delay = $urandom % (max_delay + 1);
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!(awready && wready))
            next_cycle();
        next_cycle();
        awvalid = 1'b0;
        wvalid = 1'b0;
        repeat (delay)
            next_cycle();
        bready = 1'b1;
        while (!bvalid)
            next_cycle();
        resp = bresp;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`FPU_ADDR_WIDTH-1:0] addr, input int max_delay,
                            output scalar_t data, output logic [1:0] resp);
        int delay;
        delay = $urandom % (max_delay + 1);
        araddr = addr;
        arvalid = 1'b1;
        while (!arready)
            next_cycle();
        next_cycle();
        arvalid = 1'b0;
        repeat (delay)
            next_cycle();
        rready = 1'b1;
        while (!rvalid)
            next_cycle();
        data = rdata;
        resp = rresp;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [`FPU_ADDR_WIDTH-1:0] addr, input scalar_t data,
                             input logic [1:0] expected_resp);
        logic [1:0] resp;
        axi_write(addr, data, 3, resp);
        check_value($sformatf("bresp@%h", addr), 32'(resp), 32'(expected_resp));
    endtask

    task automatic read_reg(input logic [`FPU_ADDR_WIDTH-1:0] addr,
                            input logic [1:0] expected_resp, output scalar_t data);
        logic [1:0] resp;
        axi_read(addr, 3, data, resp);
        check_value($sformatf("rresp@%h", addr), 32'(resp), 32'(expected_resp));
    endtask

    task automatic wait_done(output scalar_t status);
        do
            read_reg(`FPU_REG_STATUS, RESP_OKAY, status);
        while (!status[1]);
    endtask

    task automatic set_vector(input int idx, input fp_op_t op, input scalar_t a,
                              input scalar_t b, input scalar_t result,
                              input logic nan, input logic inf);
        vectors[idx] = {op, a, b, result, nan, inf};
    endtask

    initial
    begin
        repeat (TIMEOUT_CYCLES)
            @(posedge clk);
        fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                           TIMEOUT_CYCLES));
    end

    initial
    begin
        scalar_t data;
        scalar_t status;
        scalar_t last_status;
        scalar_t last_result;
        logic [1:0] resp;

        void'($urandom(32'hbe2797fa));
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;

        // Add and subtract
        set_vector(0, FP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000, 1'b0, 1'b0);
        set_vector(1, FP_ADD, 32'hBFC00000, 32'hC0100000, 32'hC0700000, 1'b0, 1'b0);
        set_vector(2, FP_ADD, 32'hBF800000, 32'h3E800000, 32'hBF400000, 1'b0, 1'b0);
        set_vector(3, FP_SUB, 32'h40400000, 32'h40A00000, 32'hC0000000, 1'b0, 1'b0);
        set_vector(4, FP_SUB, 32'h40200000, 32'h40200000, 32'h00000000, 1'b0, 1'b0);
        set_vector(5, FP_SUB, 32'h40A00000, 32'hC0400000, 32'h41000000, 1'b0, 1'b0);
        // Multiply with overflow from 2^100 squared
        set_vector(6, FP_MUL, 32'h3FC00000, 32'hC0800000, 32'hC0C00000, 1'b0, 1'b0);
        set_vector(7, FP_MUL, 32'h40400000, 32'h3F000000, 32'h3FC00000, 1'b0, 1'b0);
        set_vector(8, FP_MUL, 32'h71800000, 32'h71800000, 32'h7F800000, 1'b0, 1'b1);
        set_vector(9, FP_MUL, 32'h7F800000, 32'h00000000, 32'h7FC00000, 1'b1, 1'b0);
        // Float-to-int converts B
        set_vector(10, FP_FTOI, 32'h0, 32'h40F80000, 32'h00000007, 1'b0, 1'b0);
        set_vector(11, FP_FTOI, 32'h0, 32'hC0600000, 32'hFFFFFFFD, 1'b0, 1'b0);
        set_vector(12, FP_FTOI, 32'h0, 32'h3E800000, 32'h00000000, 1'b0, 1'b0);
        set_vector(13, FP_FTOI, 32'h0, 32'h4C800000, 32'h04000000, 1'b0, 1'b0);
        set_vector(14, FP_FTOI, 32'h0, 32'h4F000000, 32'h80000000, 1'b1, 1'b0);
        // NaN and infinity in add
        set_vector(15, FP_ADD, 32'h7FA00000, 32'h3F800000, 32'h7FC00000, 1'b1, 1'b0);
        set_vector(16, FP_SUB, 32'h7F800000, 32'h7F800000, 32'h7FC00000, 1'b1, 1'b0);
        set_vector(17, FP_ADD, 32'h7F800000, 32'h3F800000, 32'h7F800000, 1'b0, 1'b1);

        repeat (10)
            @(posedge clk);
        #1;
        reset = 1'b0;

        read_reg(`FPU_REG_STATUS, RESP_OKAY, data);
        check_value("status after reset", data, 32'd0);
        read_reg(`FPU_REG_RESULT, RESP_OKAY, data);
        check_value("result after reset", data, 32'd0);

        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            write_reg(`FPU_REG_OPA, vectors[i].a, RESP_OKAY);
            write_reg(`FPU_REG_OPB, vectors[i].b, RESP_OKAY);
            write_reg(`FPU_REG_CMD, 32'(vectors[i].op), RESP_OKAY);
            wait_done(status);
            check_value($sformatf("status[%0d]", i), status,
                        {28'd0, vectors[i].inf, vectors[i].nan, 2'b10});
            read_reg(`FPU_REG_RESULT, RESP_OKAY, data);
            check_value($sformatf("result[%0d]", i), data, vectors[i].result);
        end
        last_status = status;
        last_result = data;

        // Bad opcode leaves result and status alone
        write_reg(`FPU_REG_CMD, 32'd5, RESP_SLVERR);
        read_reg(`FPU_REG_STATUS, RESP_OKAY, data);
        check_value("status after bad opcode", data, last_status);
        read_reg(`FPU_REG_RESULT, RESP_OKAY, data);
        check_value("result after bad opcode", data, last_result);

        // Undefined offset
        write_reg(5'h14, 32'h12345678, RESP_SLVERR);
        read_reg(5'h14, RESP_SLVERR, data);
        check_value("rdata at undefined offset", data, 32'd0);
        read_reg(`FPU_REG_RESULT, RESP_OKAY, data);
        check_value("result after undefined offset", data, last_result);

        // Second CMD write lands while the add is still in flight
        write_reg(`FPU_REG_OPA, 32'h3FC00000, RESP_OKAY);
        write_reg(`FPU_REG_OPB, 32'h40100000, RESP_OKAY);
        axi_write(`FPU_REG_CMD, 32'(FP_ADD), 0, resp);
        check_value("bresp of first cmd", 32'(resp), 32'(RESP_OKAY));
        axi_write(`FPU_REG_CMD, 32'(FP_MUL), 0, resp);
        check_value("bresp of cmd while busy", 32'(resp), 32'(RESP_SLVERR));
        wait_done(status);
        check_value("status after busy cmd", status, 32'h00000002);
        read_reg(`FPU_REG_RESULT, RESP_OKAY, data);
        check_value("result after busy cmd", data, 32'h40700000);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: source/fp_add_stage.sv
// FPU add and convert stage
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fp_add_stage
    import fpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    align_valid,
    input  fp_op_t  align_op,
    input  fsig_t   sig_le,
    input  fsig_t   sig_se,
    input  shift_t  se_align_shift,
    input  shift_t  ftoi_lshift,
    input  fexp_t   add_exponent,
    input  logic    add_sign,
    input  logic    logical_subtract,
    input  logic    result_is_nan,
    input  logic    result_is_inf,
    output scalar_t add_result,
    output logic    add_is_nan,
    output logic    add_is_inf
);
    logic [53:0] se_wide;
    logic sticky;
    logic [26:0] se_aligned;
    logic [27:0] sum;
    shift_t lz;
    logic [27:0] norm;
    logic signed [9:0] exp_norm;
    scalar_t ftoi_mag;
    scalar_t ftoi_val;
    scalar_t add_next;
    logic overflow;

    // Three guard bits with shifted-out bits folded into a sticky LSB
    assign se_wide = {sig_se, 3'b000, 27'd0} >> se_align_shift;
    assign sticky = |se_wide[26:0];
    assign se_aligned = {se_wide[53:28], se_wide[27] | sticky};
    assign sum = logical_subtract ? {1'b0, sig_le, 3'b000} - {1'b0, se_aligned}
                                  : {1'b0, sig_le, 3'b000} + {1'b0, se_aligned};

    // Leading zero count over the sum
    always_comb
    begin
        lz = 6'd28;
        for (int i = 0; i < 28; i++)
        begin
            if (sum[i])
                lz = 6'(27 - i);
        end
    end

    // Bit 27 of the sum weighs one above the larger exponent
    assign norm = sum << lz;
    assign exp_norm = $signed({2'b00, add_exponent}) + 10'sd1 - $signed({4'b0000, lz});

    assign ftoi_mag = (scalar_t'(sig_se) >> se_align_shift) << ftoi_lshift;
    assign ftoi_val = logical_subtract ? -ftoi_mag : ftoi_mag;

    always_comb
    begin
        overflow = 1'b0;
        if (align_op == FP_FTOI)
            add_next = result_is_nan ? 32'h80000000 : ftoi_val;
        else if (result_is_nan)
            add_next = `FPU_CANON_NAN;
        else if (result_is_inf)
            add_next = {add_sign, 8'hff, 23'd0};
        else if (sum == '0)
            // Exact cancellation is +0
            add_next = {add_sign & ~logical_subtract, 31'd0};
        else if (exp_norm <= 0)
            add_next = {add_sign, 31'd0};
        else if (exp_norm >= 255)
        begin
            overflow = 1'b1;
            add_next = {add_sign, 8'hff, 23'd0};
        end
        else
            add_next = {add_sign, exp_norm[7:0], norm[26:4]};
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            add_result <= '0;
            add_is_nan <= 1'b0;
            add_is_inf <= 1'b0;
        end
        else if (align_valid)
        begin
            add_result <= add_next;
            add_is_nan <= result_is_nan;
            add_is_inf <= result_is_inf || overflow;
        end
    end

endmodule

// File: source/fp_align_stage.sv
// FPU pipeline stage one
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fp_align_stage
    import fpu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  fp_op_t            issue_op,
    input  scalar_t           opa,
    input  scalar_t           opb,
    output logic              align_valid,
    output fp_op_t            align_op,
    output logic              done_valid,
    output fp_op_t            done_op,
    output fsig_t             sig_le,
    output fsig_t             sig_se,
    output shift_t            se_align_shift,
    output shift_t            ftoi_lshift,
    output fexp_t             add_exponent,
    output logic              add_sign,
    output logic              logical_subtract,
    output logic signed [9:0] mul_exponent,
    output logic              mul_sign,
    output fsig_t             sig_a,
    output fsig_t             sig_b,
    output logic              result_is_nan,
    output logic              result_is_inf
);
    fexp_t exp_a;
    fexp_t exp_b;
    fsig_t full_a;
    fsig_t full_b;
    logic a_zero;
    logic b_zero;
    logic a_inf;
    logic b_inf;
    logic a_nan;
    logic b_nan;
    logic is_sub;
    logic is_ftoi;
    logic a_larger;
    fexp_t exp_diff;
    logic eff_sub;
    logic nan_next;
    shift_t ftoi_rshift;
    shift_t ftoi_lshift_next;

    assign exp_a = opa[30:23];
    assign exp_b = opb[30:23];
    assign a_zero = exp_a == 8'd0;
    assign b_zero = exp_b == 8'd0;
    // Subnormals flush to zero
    assign full_a = a_zero ? '0 : {1'b1, opa[22:0]};
    assign full_b = b_zero ? '0 : {1'b1, opb[22:0]};
    assign a_inf = exp_a == 8'hff && opa[22:0] == '0;
    assign b_inf = exp_b == 8'hff && opb[22:0] == '0;
    assign a_nan = exp_a == 8'hff && opa[22:0] != '0;
    assign b_nan = exp_b == 8'hff && opb[22:0] != '0;
    assign is_sub = issue_op == FP_SUB;
    assign is_ftoi = issue_op == FP_FTOI;

    // Ties keep A in the larger lane, which gives x - x its positive sign
    assign a_larger = exp_a > exp_b || (exp_a == exp_b && full_a >= full_b);
    assign exp_diff = a_larger ? exp_a - exp_b : exp_b - exp_a;
    // A negative float-to-int value is negated in stage two
    assign eff_sub = is_ftoi ? opb[31] : opa[31] ^ opb[31] ^ is_sub;

    always_comb
    begin
        case (issue_op)
            FP_MUL:
                nan_next = a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero);
            FP_FTOI:
                nan_next = b_nan || b_inf || exp_b >= 8'(`FPU_EXP_BIAS + 31);
            default:
                nan_next = a_nan || b_nan || (a_inf && b_inf && eff_sub);
        endcase
    end

    // Truncation shift for float-to-int
    // The significand LSB weighs 2^(e - 150)
    always_comb
    begin
        ftoi_lshift_next = '0;
        if (exp_b < 8'(`FPU_EXP_BIAS))
            ftoi_rshift = 6'd32;
        else if (exp_b < 8'(`FPU_EXP_BIAS + 23))
            ftoi_rshift = 6'(`FPU_EXP_BIAS + 23 - exp_b);
        else
        begin
            ftoi_rshift = '0;
            ftoi_lshift_next = 6'(exp_b - 8'(`FPU_EXP_BIAS + 23));
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            align_valid <= 1'b0;
            done_valid <= 1'b0;
        end
        else
        begin
            align_valid <= issue_valid;
            done_valid <= align_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        align_op <= issue_op;
        done_op <= align_op;
        result_is_nan <= nan_next;
        result_is_inf <= !nan_next && !is_ftoi && (a_inf || b_inf);
        logical_subtract <= eff_sub;

        if (is_ftoi)
        begin
            // Value goes down the smaller lane with nothing to add
            sig_le <= '0;
            sig_se <= full_b;
            add_exponent <= exp_b;
            add_sign <= opb[31];
            se_align_shift <= ftoi_rshift;
        end
        else
        begin
            sig_le <= a_larger ? full_a : full_b;
            sig_se <= a_larger ? full_b : full_a;
            add_exponent <= a_larger ? exp_a : exp_b;
            add_sign <= a_larger ? opa[31] : opb[31] ^ is_sub;
            // Shifting past the guard bits leaves only the sticky bit
            se_align_shift <= (exp_diff < 8'(`FPU_MAX_ALIGN)) ? 6'(exp_diff)
                                                              : 6'(`FPU_MAX_ALIGN);
        end
        ftoi_lshift <= ftoi_lshift_next;

        // Multiply path
        sig_a <= full_a;
        sig_b <= full_b;
        mul_exponent <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                        - 10'(`FPU_EXP_BIAS);
        mul_sign <= opa[31] ^ opb[31];
    end

endmodule

// File: source/fp_mul_stage.sv
// FPU multiply stage
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fp_mul_stage
    import fpu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              align_valid,
    input  logic signed [9:0] mul_exponent,
    input  logic              mul_sign,
    input  fsig_t             sig_a,
    input  fsig_t             sig_b,
    input  logic              result_is_nan,
    input  logic              result_is_inf,
    output scalar_t           mul_result,
    output logic              mul_is_nan,
    output logic              mul_is_inf
);
    logic [47:0] product;
    logic signed [9:0] exp_adj;
    logic [22:0] frac;
    logic overflow;
    scalar_t mul_next;

    assign product = sig_a * sig_b;
    // Product of two normalized significands lies in [1, 4)
    assign exp_adj = product[47] ? mul_exponent + 10'sd1 : mul_exponent;
    assign frac = product[47] ? product[46:24] : product[45:23];

    always_comb
    begin
        overflow = 1'b0;
        if (result_is_nan)
            mul_next = `FPU_CANON_NAN;
        else if (result_is_inf)
            mul_next = {mul_sign, 8'hff, 23'd0};
        else if (product[47:46] == 2'b00 || exp_adj <= 0)
            // Zero operand or underflow
            mul_next = {mul_sign, 31'd0};
        else if (exp_adj >= 255)
        begin
            overflow = 1'b1;
            mul_next = {mul_sign, 8'hff, 23'd0};
        end
        else
            mul_next = {mul_sign, exp_adj[7:0], frac};
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            mul_result <= '0;
            mul_is_nan <= 1'b0;
            mul_is_inf <= 1'b0;
        end
        else if (align_valid)
        begin
            mul_result <= mul_next;
            mul_is_nan <= result_is_nan;
            mul_is_inf <= result_is_inf || overflow;
        end
    end

endmodule

// File: source/fpu_axil_ctrl.sv
// FPU AXI4-Lite register block
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_axil_ctrl
    import fpu_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`FPU_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  scalar_t                    wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [`FPU_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output scalar_t                    rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       issue_valid,
    output fp_op_t                     issue_op,
    output scalar_t                    opa,
    output scalar_t                    opb,
    input  logic                       done_valid,
    input  fp_op_t                     done_op,
    input  scalar_t                    add_result,
    input  logic                       add_is_nan,
    input  logic                       add_is_inf,
    input  scalar_t                    mul_result,
    input  logic                       mul_is_nan,
    input  logic                       mul_is_inf
);
    axil_state_t w_state;
    logic wr_hs;
    logic rd_hs;
    logic cmd_ok;
    logic wr_err;
    logic busy;
    logic done;
    logic res_nan;
    logic res_inf;
    scalar_t result;
    scalar_t status;
    scalar_t rd_data;
    logic rd_err;

    assign wr_hs = w_state == W_IDLE && awready && awvalid && wvalid;
    assign rd_hs = arready && arvalid;
    assign cmd_ok = wdata < 32'd4 && !busy;
    assign status = {28'd0, res_inf, res_nan, done, busy};

    // RESULT and STATUS are read only
    always_comb
    begin
        case (awaddr)
            `FPU_REG_OPA, `FPU_REG_OPB: wr_err = 1'b0;
            `FPU_REG_CMD: wr_err = !cmd_ok;
            default: wr_err = 1'b1;
        endcase
    end

    always_comb
    begin
        rd_err = 1'b0;
        case (araddr)
            `FPU_REG_OPA: rd_data = opa;
            `FPU_REG_OPB: rd_data = opb;
            `FPU_REG_CMD: rd_data = {30'd0, issue_op};
            `FPU_REG_RESULT: rd_data = result;
            `FPU_REG_STATUS: rd_data = status;
            default:
            begin
                rd_data = '0;
                rd_err = 1'b1;
            end
        endcase
    end

    // Write channel, issue and result capture
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            w_state <= W_IDLE;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            issue_valid <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            res_nan <= 1'b0;
            res_inf <= 1'b0;
            result <= '0;
        end
        else
        begin
            issue_valid <= 1'b0;
            case (w_state)
                W_IDLE:
                begin
                    if (wr_hs)
                    begin
                        awready <= 1'b0;
                        wready <= 1'b0;
                        bvalid <= 1'b1;
                        w_state <= W_RESP;
                        if (awaddr == `FPU_REG_CMD && cmd_ok)
                        begin
                            issue_valid <= 1'b1;
                            busy <= 1'b1;
                            done <= 1'b0;
                        end
                    end
                    else if (awvalid && wvalid)
                    begin
                        awready <= 1'b1;
                        wready <= 1'b1;
                    end
                end
                W_RESP:
                begin
                    if (bready)
                    begin
                        bvalid <= 1'b0;
                        w_state <= W_IDLE;
                    end
                end
            endcase

            if (done_valid)
            begin
                result <= (done_op == FP_MUL) ? mul_result : add_result;
                res_nan <= (done_op == FP_MUL) ? mul_is_nan : add_is_nan;
                res_inf <= (done_op == FP_MUL) ? mul_is_inf : add_is_inf;
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Read address and data channel
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            if (rd_hs)
            begin
                arready <= 1'b0;
                rvalid <= 1'b1;
            end
            else if (arvalid && !arready && !rvalid)
                arready <= 1'b1;
            if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    // Operands and response payloads with SLVERR as 2'b10
    always_ff @(posedge clk)
    begin
        if (wr_hs)
        begin
            bresp <= wr_err ? 2'b10 : 2'b00;
            if (awaddr == `FPU_REG_OPA)
                opa <= wdata;
            if (awaddr == `FPU_REG_OPB)
                opb <= wdata;
            if (awaddr == `FPU_REG_CMD && cmd_ok)
                issue_op <= fp_op_t'(wdata[1:0]);
        end
        if (rd_hs)
        begin
            rdata <= rd_data;
            rresp <= rd_err ? 2'b10 : 2'b00;
        end
    end

endmodule

// File: source/fpu_defs.svh
// FPU register map and float constants
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// AXI4-Lite register offsets
`define FPU_ADDR_WIDTH 5
`define FPU_REG_OPA    5'h00
`define FPU_REG_OPB    5'h04
`define FPU_REG_CMD    5'h08
`define FPU_REG_RESULT 5'h0C
`define FPU_REG_STATUS 5'h10

// Single-precision field constants
`define FPU_CANON_NAN  32'h7FC00000
`define FPU_EXP_BIAS   127
`define FPU_MAX_ALIGN  27

`endif

// File: source/fpu_pkg.sv
// FPU shared types
package fpu_pkg;

    // Raw operand, result or integer word
    typedef logic [31:0] scalar_t;

    // Biased exponent
    typedef logic [7:0] fexp_t;

    // Significand with the hidden bit
    typedef logic [23:0] fsig_t;

    typedef logic [5:0] shift_t;

    // Low bits of the CMD register write
    typedef enum logic [1:0] {
        FP_ADD  = 2'd0,
        FP_SUB  = 2'd1,
        FP_MUL  = 2'd2,
        FP_FTOI = 2'd3
    } fp_op_t;

    typedef enum logic {
        W_IDLE,
        W_RESP
    } axil_state_t;

endpackage

// File: source/fpu_top.sv
// FPU coprocessor top level
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_top
    import fpu_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`FPU_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  scalar_t                    wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [`FPU_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output scalar_t                    rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    logic issue_valid;
    fp_op_t issue_op;
    scalar_t opa;
    scalar_t opb;
    logic align_valid;
    fp_op_t align_op;
    logic done_valid;
    fp_op_t done_op;
    fsig_t sig_le;
    fsig_t sig_se;
    shift_t se_align_shift;
    shift_t ftoi_lshift;
    fexp_t add_exponent;
    logic add_sign;
    logic logical_subtract;
    logic signed [9:0] mul_exponent;
    logic mul_sign;
    fsig_t sig_a;
    fsig_t sig_b;
    logic result_is_nan;
    logic result_is_inf;
    scalar_t add_result;
    logic add_is_nan;
    logic add_is_inf;
    scalar_t mul_result;
    logic mul_is_nan;
    logic mul_is_inf;

    fpu_axil_ctrl u_ctrl (.*);

    fp_align_stage u_align (.*);

    // Both second stages run on every operation and control picks by done_op
    fp_add_stage u_add (.*);

    fp_mul_stage u_mul (.*);

endmodule
